//--- id_branch_unit.sv
// branch unit, operand compare and jump or branch target for fetch
`timescale 1ns/1ns

module id_branch_unit (
  input  logic [id_pkg::XLEN-1:0] i_rs1data,
  input  logic [id_pkg::XLEN-1:0] i_rs2data,
  input  logic [id_pkg::XLEN-1:0] i_pc,
  input  logic [id_pkg::XLEN-1:0] i_imm,
  input  logic                    i_is_branch,
  input  logic                    i_is_jal,
  input  logic                    i_is_jalr,
  input  id_pkg::br_func_e        i_br_func,
  output logic                    o_is_cti,
  output logic                    o_cond_taken,
  output logic [id_pkg::XLEN-1:0] o_target
);

  logic                    eq;
  logic                    lt;
  logic                    ltu;
  logic                    cmp;
  logic [id_pkg::XLEN-1:0] jalr_sum;

  assign eq  = (i_rs1data == i_rs2data);
  assign lt  = ($signed(i_rs1data) < $signed(i_rs2data));
  assign ltu = (i_rs1data < i_rs2data);

  always_comb begin
    case (i_br_func)
      id_pkg::BEQ:  cmp = eq;
      id_pkg::BNE:  cmp = !eq;
      id_pkg::BLT:  cmp = lt;
      id_pkg::BGE:  cmp = !lt;
      id_pkg::BLTU: cmp = ltu;
      id_pkg::BGEU: cmp = !ltu;
      default:      cmp = 1'b0;
    endcase
  end

  assign o_is_cti     = i_is_branch || i_is_jal || i_is_jalr;
  assign o_cond_taken = i_is_jal || i_is_jalr || (i_is_branch && cmp); // jumps always go
  assign jalr_sum     = i_rs1data + i_imm;
  assign o_target     = i_is_jalr ? {jalr_sum[id_pkg::XLEN-1:1], 1'b0} : i_pc + i_imm;

endmodule

//--- id_decoder.sv
// instruction decoder, field extraction, immediates and execute controls
`timescale 1ns/1ns

module id_decoder (
  input  logic [id_pkg::INST_W-1:0]     i_inst,
  output logic [id_pkg::GPR_ADDR_W-1:0] o_rs1,
  output logic [id_pkg::GPR_ADDR_W-1:0] o_rs2,
  output logic [id_pkg::GPR_ADDR_W-1:0] o_rd,
  output logic [id_pkg::XLEN-1:0]       o_imm,
  output id_pkg::alu_op_e               o_alu_op,
  output id_pkg::src1_e                 o_src1_sel,
  output id_pkg::src2_e                 o_src2_sel,
  output logic                          o_gpr_wen,
  output logic                          o_mem_ren,
  output logic                          o_mem_wen,
  output logic [2:0]                    o_mem_op,
  output logic                          o_is_branch,
  output logic                          o_is_jal,
  output logic                          o_is_jalr,
  output id_pkg::br_func_e              o_br_func,
  output logic                          o_invalid
);

  id_pkg::opcode_e         opcode;
  id_pkg::alu_op_e         alu_f3;  // alu op from funct3 alone
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [id_pkg::XLEN-1:0] imm_i;
  logic [id_pkg::XLEN-1:0] imm_s;
  logic [id_pkg::XLEN-1:0] imm_b;
  logic [id_pkg::XLEN-1:0] imm_u;
  logic [id_pkg::XLEN-1:0] imm_j;
  logic                    shift_ok;
  logic                    op_ok;

  assign opcode    = id_pkg::opcode_e'(i_inst[6:0]);
  assign funct3    = i_inst[14:12];
  assign funct7    = i_inst[31:25];
  assign o_rs1     = i_inst[19:15];
  assign o_rs2     = i_inst[24:20];
  assign o_rd      = i_inst[11:7];
  assign o_mem_op  = funct3;   // size and sign for ms
  assign o_br_func = id_pkg::br_func_e'(funct3);

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // rv64 shifts take a 6-bit shamt, funct6 above it
  assign shift_ok = (funct3 == 3'b001) ? (i_inst[31:26] == 6'b000000) :
                    (funct3 == 3'b101) ? (i_inst[31:26] == 6'b000000 ||
                                          i_inst[31:26] == 6'b010000) : 1'b1;
  assign op_ok    = (funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  always_comb begin
    case (funct3)
      3'b000:  alu_f3 = id_pkg::ADD;
      3'b001:  alu_f3 = id_pkg::SLL;
      3'b010:  alu_f3 = id_pkg::SLT;
      3'b011:  alu_f3 = id_pkg::SLTU;
      3'b100:  alu_f3 = id_pkg::XOR;
      3'b101:  alu_f3 = i_inst[30] ? id_pkg::SRA : id_pkg::SRL;
      3'b110:  alu_f3 = id_pkg::OR;
      default: alu_f3 = id_pkg::AND;
    endcase
  end

  always_comb begin
    o_imm       = imm_i;
    o_alu_op    = id_pkg::ADD;
    o_src1_sel  = id_pkg::SRC1_RS1;
    o_src2_sel  = id_pkg::SRC2_RS2;
    o_gpr_wen   = 1'b0;
    o_mem_ren   = 1'b0;
    o_mem_wen   = 1'b0;
    o_is_branch = 1'b0;
    o_is_jal    = 1'b0;
    o_is_jalr   = 1'b0;
    o_invalid   = 1'b0;
    case (opcode)
      id_pkg::OP_IMM: begin
        o_alu_op   = alu_f3;
        o_src2_sel = id_pkg::SRC2_IMM;
        o_gpr_wen  = shift_ok;
        o_invalid  = !shift_ok;
      end
      id_pkg::OP: begin
        o_alu_op  = (funct3 == 3'b000 && funct7[5]) ? id_pkg::SUB : alu_f3;
        o_gpr_wen = op_ok;
        o_invalid = !op_ok;
      end
      id_pkg::LUI: begin
        o_imm      = imm_u;
        o_alu_op   = id_pkg::PASS_B;
        o_src2_sel = id_pkg::SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      id_pkg::AUIPC: begin
        o_imm      = imm_u;
        o_src1_sel = id_pkg::SRC1_PC;
        o_src2_sel = id_pkg::SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      id_pkg::JAL: begin
        o_imm      = imm_j;
        o_src1_sel = id_pkg::SRC1_PC;   // link value pc + 4
        o_src2_sel = id_pkg::SRC2_FOUR;
        o_gpr_wen  = 1'b1;
        o_is_jal   = 1'b1;
      end
      id_pkg::JALR: begin
        o_src1_sel = id_pkg::SRC1_PC;
        o_src2_sel = id_pkg::SRC2_FOUR;
        o_gpr_wen  = (funct3 == 3'b000);
        o_is_jalr  = (funct3 == 3'b000);
        o_invalid  = (funct3 != 3'b000);
      end
      id_pkg::BRANCH: begin
        o_imm       = imm_b;
        o_is_branch = (funct3[2:1] != 2'b01); // 010 and 011 unused
        o_invalid   = (funct3[2:1] == 2'b01);
      end
      id_pkg::LOAD: begin
        o_src2_sel = id_pkg::SRC2_IMM;
        o_gpr_wen  = (funct3 != 3'b111);
        o_mem_ren  = (funct3 != 3'b111);
        o_invalid  = (funct3 == 3'b111);
      end
      id_pkg::STORE: begin
        o_imm      = imm_s;
        o_src2_sel = id_pkg::SRC2_IMM;
        o_mem_wen  = !funct3[2];  // sb sh sw sd only
        o_invalid  = funct3[2];
      end
      default: o_invalid = 1'b1;
    endcase
  end

endmodule

//--- id_pipe_ctrl.sv
// id stage pipeline control, valid bit, inst/pc register and raw hazard stall
`timescale 1ns/1ns

module id_pipe_ctrl (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_fs_valid,
  input  logic [id_pkg::INST_W-1:0]     i_fs_inst,
  input  logic [id_pkg::XLEN-1:0]       i_fs_pc,
  input  logic                          i_es_allowin,
  input  logic [id_pkg::GPR_ADDR_W-1:0] i_rs1,
  input  logic [id_pkg::GPR_ADDR_W-1:0] i_rs2,
  input  logic [id_pkg::GPR_ADDR_W-1:0] i_es_rd,
  input  logic [id_pkg::GPR_ADDR_W-1:0] i_ms_rd,
  input  logic [id_pkg::GPR_ADDR_W-1:0] i_ws_rd,
  input  logic                          i_is_cti,
  input  logic                          i_cond_taken,
  output logic [id_pkg::INST_W-1:0]     o_inst,
  output logic [id_pkg::XLEN-1:0]       o_pc,
  output logic                          o_ds_allowin,
  output logic                          o_es_valid,
  output logic                          o_br_taken,
  output logic                          o_br_stall
);

  logic ds_valid;
  logic ds_ready_go;
  logic hazard;

  // rd of 0 means no write pending
  function automatic logic rd_hit(input logic [id_pkg::GPR_ADDR_W-1:0] rd,
                                  input logic [id_pkg::GPR_ADDR_W-1:0] rs1,
                                  input logic [id_pkg::GPR_ADDR_W-1:0] rs2);
    return (rd != '0) && (rd == rs1 || rd == rs2);
  endfunction

  assign hazard       = rd_hit(i_es_rd, i_rs1, i_rs2) || rd_hit(i_ms_rd, i_rs1, i_rs2) ||
                        rd_hit(i_ws_rd, i_rs1, i_rs2);
  assign ds_ready_go  = !hazard;
  assign o_ds_allowin = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_es_valid   = ds_valid && ds_ready_go;
  assign o_br_taken   = o_es_valid && i_cond_taken;
  assign o_br_stall   = ds_valid && i_is_cti && hazard; // resolve once operands are safe

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      o_inst <= i_fs_inst;
      o_pc   <= i_fs_pc;
    end
  end

endmodule

//--- id_pkg.sv
// id stage shared widths and decode encodings for the rv64i subset
package id_pkg;

  localparam int XLEN       = 64; // register and pc width
  localparam int INST_W     = 32;
  localparam int GPR_ADDR_W = 5;
  localparam int GPR_NUM    = 32;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_e;

  typedef enum logic [3:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    SLL    = 4'd2,
    SLT    = 4'd3,
    SLTU   = 4'd4,
    XOR    = 4'd5,
    SRL    = 4'd6,
    SRA    = 4'd7,
    OR     = 4'd8,
    AND    = 4'd9,
    PASS_B = 4'd10  // lui, operand 2 straight through
  } alu_op_e;

  // same codes as branch funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } br_func_e;

  typedef enum logic {SRC1_RS1 = 1'b0, SRC1_PC = 1'b1} src1_e;

  typedef enum logic [1:0] {SRC2_RS2 = 2'd0, SRC2_IMM = 2'd1, SRC2_FOUR = 2'd2} src2_e;

endpackage

//--- id_regfile.sv
// general register file, 32 x 64, two combinational reads and one clocked write
`timescale 1ns/1ns

module id_regfile (
  input  logic                          i_clk,
  input  logic [id_pkg::GPR_ADDR_W-1:0] i_raddr1,
  input  logic [id_pkg::GPR_ADDR_W-1:0] i_raddr2,
  input  logic                          i_wen,
  input  logic [id_pkg::GPR_ADDR_W-1:0] i_waddr,
  input  logic [id_pkg::XLEN-1:0]       i_wdata,
  output logic [id_pkg::XLEN-1:0]       o_rdata1,
  output logic [id_pkg::XLEN-1:0]       o_rdata2
);

  logic [id_pkg::XLEN-1:0] regs [id_pkg::GPR_NUM];

  always_ff @(posedge i_clk) begin
    if (i_wen && i_waddr != '0) begin // x0 stays zero
      regs[i_waddr] <= i_wdata;
    end
  end

  // no bypass, the ws rd compare stalls instead
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

//--- id_stage.sv
// instruction decode stage, rv64i decode, register read and branch resolve
`timescale 1ns/1ns

module id_stage (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_fs_valid,
  input  logic [id_pkg::INST_W-1:0]     i_fs_inst,
  input  logic [id_pkg::XLEN-1:0]       i_fs_pc,
  input  logic                          i_es_allowin,
  input  logic [id_pkg::GPR_ADDR_W-1:0] i_es_rd,
  input  logic [id_pkg::GPR_ADDR_W-1:0] i_ms_rd,
  input  logic [id_pkg::GPR_ADDR_W-1:0] i_ws_rd,
  input  logic                          i_wb_wen,
  input  logic [id_pkg::GPR_ADDR_W-1:0] i_wb_waddr,
  input  logic [id_pkg::XLEN-1:0]       i_wb_wdata,
  output logic                          o_ds_allowin,
  output logic                          o_es_valid,
  output logic [id_pkg::XLEN-1:0]       o_es_rs1data,
  output logic [id_pkg::XLEN-1:0]       o_es_rs2data,
  output logic [id_pkg::XLEN-1:0]       o_es_imm,
  output logic [id_pkg::XLEN-1:0]       o_es_pc,
  output id_pkg::alu_op_e               o_es_alu_op,
  output id_pkg::src1_e                 o_es_src1_sel,
  output id_pkg::src2_e                 o_es_src2_sel,
  output logic [id_pkg::GPR_ADDR_W-1:0] o_es_rd,
  output logic                          o_es_gpr_wen,
  output logic                          o_es_mem_ren,
  output logic                          o_es_mem_wen,
  output logic [2:0]                    o_es_mem_op,
  output logic                          o_es_invalid,
  output logic                          o_br_taken,
  output logic [id_pkg::XLEN-1:0]       o_br_target,
  output logic                          o_br_stall
);

  logic [id_pkg::INST_W-1:0]     ds_inst;
  logic [id_pkg::GPR_ADDR_W-1:0] rs1;
  logic [id_pkg::GPR_ADDR_W-1:0] rs2;
  logic                          is_branch;
  logic                          is_jal;
  logic                          is_jalr;
  id_pkg::br_func_e              br_func;
  logic                          is_cti;
  logic                          cond_taken; // raw, before es valid gating

  id_pipe_ctrl id_pipe_ctrl_inst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_fs_valid   (i_fs_valid),
    .i_fs_inst    (i_fs_inst),
    .i_fs_pc      (i_fs_pc),
    .i_es_allowin (i_es_allowin),
    .i_rs1        (rs1),
    .i_rs2        (rs2),
    .i_es_rd      (i_es_rd),
    .i_ms_rd      (i_ms_rd),
    .i_ws_rd      (i_ws_rd),
    .i_is_cti     (is_cti),
    .i_cond_taken (cond_taken),
    .o_inst       (ds_inst),
    .o_pc         (o_es_pc),
    .o_ds_allowin (o_ds_allowin),
    .o_es_valid   (o_es_valid),
    .o_br_taken   (o_br_taken),
    .o_br_stall   (o_br_stall)
  );

  id_decoder id_decoder_inst (
    .i_inst      (ds_inst),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_rd        (o_es_rd),
    .o_imm       (o_es_imm),
    .o_alu_op    (o_es_alu_op),
    .o_src1_sel  (o_es_src1_sel),
    .o_src2_sel  (o_es_src2_sel),
    .o_gpr_wen   (o_es_gpr_wen),
    .o_mem_ren   (o_es_mem_ren),
    .o_mem_wen   (o_es_mem_wen),
    .o_mem_op    (o_es_mem_op),
    .o_is_branch (is_branch),
    .o_is_jal    (is_jal),
    .o_is_jalr   (is_jalr),
    .o_br_func   (br_func),
    .o_invalid   (o_es_invalid)
  );

  id_regfile id_regfile_inst (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wen    (i_wb_wen),   // write back from ws
    .i_waddr  (i_wb_waddr),
    .i_wdata  (i_wb_wdata),
    .o_rdata1 (o_es_rs1data),
    .o_rdata2 (o_es_rs2data)
  );

  id_branch_unit id_branch_unit_inst (
    .i_rs1data    (o_es_rs1data),
    .i_rs2data    (o_es_rs2data),
    .i_pc         (o_es_pc),
    .i_imm        (o_es_imm),
    .i_is_branch  (is_branch),
    .i_is_jal     (is_jal),
    .i_is_jalr    (is_jalr),
    .i_br_func    (br_func),
    .o_is_cti     (is_cti),
    .o_cond_taken (cond_taken),
    .o_target     (o_br_target)
  );

endmodule

//--- run.sh
#!/bin/sh
# build and run the id stage testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_id_stage -o sim_id_stage
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi
./obj_dir/sim_id_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if grep -q "CHECKS FAILED" sim.log; then
  exit 1
fi
exit 0

//--- tb_id_stage.sv
// testbench for the id stage, directed decode, branch, hazard and handshake tests
`timescale 1ns/1ns

module tb_id_stage;

  logic                          i_clk = 1'b0;
  logic                          i_rst_n;
  logic                          i_fs_valid;
  logic [id_pkg::INST_W-1:0]     i_fs_inst;
  logic [id_pkg::XLEN-1:0]       i_fs_pc;
  logic                          i_es_allowin;
  logic [id_pkg::GPR_ADDR_W-1:0] i_es_rd;
  logic [id_pkg::GPR_ADDR_W-1:0] i_ms_rd;
  logic [id_pkg::GPR_ADDR_W-1:0] i_ws_rd;
  logic                          i_wb_wen;
  logic [id_pkg::GPR_ADDR_W-1:0] i_wb_waddr;
  logic [id_pkg::XLEN-1:0]       i_wb_wdata;
  logic                          o_ds_allowin;
  logic                          o_es_valid;
  logic [id_pkg::XLEN-1:0]       o_es_rs1data;
  logic [id_pkg::XLEN-1:0]       o_es_rs2data;
  logic [id_pkg::XLEN-1:0]       o_es_imm;
  logic [id_pkg::XLEN-1:0]       o_es_pc;
  id_pkg::alu_op_e               o_es_alu_op;
  id_pkg::src1_e                 o_es_src1_sel;
  id_pkg::src2_e                 o_es_src2_sel;
  logic [id_pkg::GPR_ADDR_W-1:0] o_es_rd;
  logic                          o_es_gpr_wen;
  logic                          o_es_mem_ren;
  logic                          o_es_mem_wen;
  logic [2:0]                    o_es_mem_op;
  logic                          o_es_invalid;
  logic                          o_br_taken;
  logic [id_pkg::XLEN-1:0]       o_br_target;
  logic                          o_br_stall;

  int          errors;
  logic [15:0] lfsr_state;

  id_stage id_stage_inst (.*);

  always #5 i_clk = ~i_clk;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // taps 16 14 13 11
  endfunction

  task automatic rand_word(output logic [63:0] v);
    v = '0;
    for (int i = 0; i < 64; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
  endtask

  // rv instruction formats
  function automatic logic [31:0] enc_i(input logic [63:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_s(input logic [63:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [63:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [63:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm[31:12], rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [63:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic branch_expect(input logic [2:0] f3, input logic [63:0] a,
                                         input logic [63:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      errors++;
      $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timeout at %0t ns while waiting for %s", $time, what);
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [63:0] data);
    @(posedge i_clk);
    i_wb_wen   <= 1'b1;
    i_wb_waddr <= addr;
    i_wb_wdata <= data;
    @(posedge i_clk);
    i_wb_wen <= 1'b0;
  endtask

  // returns at the falling edge after the capture edge
  task automatic issue(input logic [31:0] inst, input logic [63:0] pc);
    int n;
    n = 0;
    @(posedge i_clk);
    i_fs_valid <= 1'b1;
    i_fs_inst  <= inst;
    i_fs_pc    <= pc;
    @(negedge i_clk);
    while (!o_ds_allowin && n < 20) begin
      @(negedge i_clk);
      n++;
    end
    assert (o_ds_allowin) else report_timeout("o_ds_allowin");
    @(posedge i_clk);
    i_fs_valid <= 1'b0;
    @(negedge i_clk);
  endtask

  // called at a falling edge
  task automatic wait_es_valid;
    int n;
    n = 0;
    while (!o_es_valid && n < 20) begin
      @(negedge i_clk);
      n++;
    end
    assert (o_es_valid) else report_timeout("o_es_valid");
  endtask

  task automatic check_decode(input id_pkg::alu_op_e alu, input id_pkg::src1_e s1,
                              input id_pkg::src2_e s2, input logic [4:0] rd,
                              input logic wen);
    check_val("o_es_alu_op", 64'(alu), 64'(o_es_alu_op));
    check_val("o_es_src1_sel", 64'(s1), 64'(o_es_src1_sel));
    check_val("o_es_src2_sel", 64'(s2), 64'(o_es_src2_sel));
    check_val("o_es_rd", 64'(rd), 64'(o_es_rd));
    check_val("o_es_gpr_wen", 64'(wen), 64'(o_es_gpr_wen));
  endtask

  task automatic test_reset;
    check_val("o_es_valid", 64'd0, 64'(o_es_valid));
    check_val("o_br_taken", 64'd0, 64'(o_br_taken));
    check_val("o_br_stall", 64'd0, 64'(o_br_stall));
    check_val("o_ds_allowin", 64'd1, 64'(o_ds_allowin));
  endtask

  task automatic test_alu;
    logic [63:0] a;
    logic [63:0] b;
    rand_word(a);
    rand_word(b);
    write_reg(5'd0, a); // must not land
    write_reg(5'd5, a);
    write_reg(5'd6, b);
    issue(enc_i(-64'd5, 5'd0, 3'b000, 5'd8, id_pkg::OP_IMM), 64'h8000_1000);
    wait_es_valid();
    check_decode(id_pkg::ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_IMM, 5'd8, 1'b1);
    check_val("o_es_imm", -64'd5, o_es_imm);
    check_val("o_es_rs1data", 64'd0, o_es_rs1data);
    issue(enc_r(7'b0000000, 5'd6, 5'd5, 3'b000, 5'd7), 64'h8000_1004);
    wait_es_valid();
    check_decode(id_pkg::ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2, 5'd7, 1'b1);
    check_val("o_es_rs1data", a, o_es_rs1data);
    check_val("o_es_rs2data", b, o_es_rs2data);
    issue(enc_r(7'b0100000, 5'd6, 5'd5, 3'b000, 5'd9), 64'h8000_1008);
    wait_es_valid();
    check_decode(id_pkg::SUB, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2, 5'd9, 1'b1);
    issue(enc_u(64'h8000_0000, 5'd10, id_pkg::LUI), 64'h8000_100C);
    wait_es_valid();
    check_decode(id_pkg::PASS_B, id_pkg::SRC1_RS1, id_pkg::SRC2_IMM, 5'd10, 1'b1);
    check_val("o_es_imm", 64'hFFFF_FFFF_8000_0000, o_es_imm);
    issue(enc_u(64'h1234_5000, 5'd11, id_pkg::AUIPC), 64'h8000_1010);
    wait_es_valid();
    check_decode(id_pkg::ADD, id_pkg::SRC1_PC, id_pkg::SRC2_IMM, 5'd11, 1'b1);
    check_val("o_es_imm", 64'h0000_0000_1234_5000, o_es_imm);
    check_val("o_es_pc", 64'h8000_1010, o_es_pc);
  endtask

  task automatic test_branch;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] pc;
    pc = 64'h8000_2000;
    for (int r = 0; r < 2; r++) begin
      for (int f = 0; f < 8; f++) begin
        if (f[2:1] == 2'b01) continue;  // no branch on funct3 010, 011
        rand_word(a);
        rand_word(b);
        if (r == 1) b = a;
        write_reg(5'd5, a);
        write_reg(5'd6, b);
        issue(enc_b(-64'd16, 5'd6, 5'd5, f[2:0]), pc);
        wait_es_valid();
        check_val("o_br_taken", 64'(branch_expect(f[2:0], a, b)), 64'(o_br_taken));
        check_val("o_br_target", pc - 64'd16, o_br_target);
        check_val("o_br_stall", 64'd0, 64'(o_br_stall));
      end
    end
    issue(enc_j(64'd2048, 5'd1), pc);
    wait_es_valid();
    check_val("o_br_taken", 64'd1, 64'(o_br_taken));
    check_val("o_br_target", pc + 64'd2048, o_br_target);
    check_decode(id_pkg::ADD, id_pkg::SRC1_PC, id_pkg::SRC2_FOUR, 5'd1, 1'b1);
    issue(enc_i(-64'd3, 5'd5, 3'b000, 5'd1, id_pkg::JALR), pc);
    wait_es_valid();
    check_val("o_br_taken", 64'd1, 64'(o_br_taken));
    check_val("o_br_target", (a - 64'd3) & ~64'd1, o_br_target);
  endtask

  task automatic test_hazard;
    logic [4:0] rd;
    for (int k = 0; k < 6; k++) begin
      rd = (k < 3) ? 5'd5 : 5'd6;  // rs1 first, then rs2
      @(posedge i_clk);
      case (k % 3)
        0:       i_es_rd <= rd;
        1:       i_ms_rd <= rd;
        default: i_ws_rd <= rd;
      endcase
      issue(enc_b(-64'd16, 5'd6, 5'd5, 3'b000), 64'h8000_3000);
      check_val("o_es_valid", 64'd0, 64'(o_es_valid));
      check_val("o_ds_allowin", 64'd0, 64'(o_ds_allowin));
      check_val("o_br_stall", 64'd1, 64'(o_br_stall));
      check_val("o_br_taken", 64'd0, 64'(o_br_taken));
      @(posedge i_clk);
      i_es_rd <= '0;
      i_ms_rd <= '0;
      i_ws_rd <= '0;
      @(negedge i_clk);
      wait_es_valid();
      check_val("o_br_stall", 64'd0, 64'(o_br_stall));
    end
    // beq x0, x0 against rd 0 everywhere
    issue(enc_b(64'd8, 5'd0, 5'd0, 3'b000), 64'h8000_3100);
    check_val("o_es_valid", 64'd1, 64'(o_es_valid));
    check_val("o_br_stall", 64'd0, 64'(o_br_stall));
    check_val("o_br_taken", 64'd1, 64'(o_br_taken));
  endtask

  task automatic test_backpressure;
    @(posedge i_clk);
    i_es_allowin <= 1'b0;
    issue(enc_i(64'd100, 5'd5, 3'b000, 5'd13, id_pkg::OP_IMM), 64'h8000_5000);
    wait_es_valid();
    @(posedge i_clk);
    i_fs_valid <= 1'b1;
    i_fs_inst  <= enc_i(64'd200, 5'd6, 3'b000, 5'd14, id_pkg::OP_IMM);
    i_fs_pc    <= 64'h8000_5004;
    repeat (3) begin
      @(negedge i_clk);
      check_val("o_es_pc", 64'h8000_5000, o_es_pc);
      check_val("o_es_imm", 64'd100, o_es_imm);
      check_val("o_es_rd", 64'd13, 64'(o_es_rd));
      check_val("o_es_valid", 64'd1, 64'(o_es_valid));
      check_val("o_ds_allowin", 64'd0, 64'(o_ds_allowin));
    end
    @(posedge i_clk);
    i_es_allowin <= 1'b1;
    @(posedge i_clk);  // held fetch taken here
    i_fs_valid <= 1'b0;
    @(negedge i_clk);
    check_val("o_es_pc", 64'h8000_5004, o_es_pc);
    check_val("o_es_rd", 64'd14, 64'(o_es_rd));
    check_val("o_es_imm", 64'd200, o_es_imm);
  endtask

  task automatic test_mem_invalid;
    issue(enc_i(-64'd8, 5'd5, 3'b011, 5'd12, id_pkg::LOAD), 64'h8000_6000);
    wait_es_valid();
    check_val("o_es_mem_ren", 64'd1, 64'(o_es_mem_ren));
    check_val("o_es_mem_wen", 64'd0, 64'(o_es_mem_wen));
    check_val("o_es_mem_op", 64'd3, 64'(o_es_mem_op));
    check_val("o_es_imm", -64'd8, o_es_imm);
    check_decode(id_pkg::ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_IMM, 5'd12, 1'b1);
    issue(enc_s(64'd2036, 5'd6, 5'd5, 3'b010), 64'h8000_6004);
    wait_es_valid();
    check_val("o_es_mem_wen", 64'd1, 64'(o_es_mem_wen));
    check_val("o_es_mem_ren", 64'd0, 64'(o_es_mem_ren));
    check_val("o_es_gpr_wen", 64'd0, 64'(o_es_gpr_wen));
    check_val("o_es_mem_op", 64'd2, 64'(o_es_mem_op));
    check_val("o_es_imm", 64'd2036, o_es_imm);
    issue(enc_s(-64'd100, 5'd6, 5'd5, 3'b011), 64'h8000_6008);
    wait_es_valid();
    check_val("o_es_imm", -64'd100, o_es_imm);
    check_val("o_es_mem_op", 64'd3, 64'(o_es_mem_op));
    issue(32'h0000_007F, 64'h8000_600C);
    wait_es_valid();
    check_val("o_es_invalid", 64'd1, 64'(o_es_invalid));
    check_val("o_es_gpr_wen", 64'd0, 64'(o_es_gpr_wen));
    check_val("o_es_mem_ren", 64'd0, 64'(o_es_mem_ren));
    check_val("o_es_mem_wen", 64'd0, 64'(o_es_mem_wen));
  endtask

  initial begin
    errors       = 0;
    lfsr_state   = 16'd54;
    i_rst_n      = 1'b0;
    i_fs_valid   = 1'b0;
    i_fs_inst    = '0;
    i_fs_pc      = '0;
    i_es_allowin = 1'b1;
    i_es_rd      = '0;
    i_ms_rd      = '0;
    i_ws_rd      = '0;
    i_wb_wen     = 1'b0;
    i_wb_waddr   = '0;
    i_wb_wdata   = '0;
    repeat (10) @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(negedge i_clk);
    test_reset();
    test_alu();
    test_branch();
    test_hazard();
    test_backpressure();
    test_mem_invalid();
    // bound assertion failures count as errors too
    errors += id_stage_inst.tb_id_stage_assertions_inst.taken_fails;
    errors += id_stage_inst.tb_id_stage_assertions_inst.reset_fails;
    errors += id_stage_inst.tb_id_stage_assertions_inst.hold_fails;
    $display("error count: %0d", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- tb_id_stage_assertions.sv
// bound checks on the id stage handshake and branch outputs
`timescale 1ns/1ns

module tb_id_stage_assertions (
  input logic                    i_clk,
  input logic                    i_rst_n,
  input logic                    i_es_allowin,
  input logic                    o_es_valid,
  input logic [id_pkg::XLEN-1:0] o_es_pc,
  input logic                    o_br_taken,
  input logic                    o_br_stall
);

  // failure counts, summed by the testbench at the end
  int taken_fails = 0;
  int reset_fails = 0;
  int hold_fails  = 0;

  // taken needs ready, stall needs a hazard
  taken_not_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_br_taken && o_br_stall))
    else begin
      $error("o_br_taken and o_br_stall high together");
      taken_fails++;
    end

  valid_low_after_reset: assert property (@(posedge i_clk) !i_rst_n |=> !o_es_valid)
    else begin
      $error("o_es_valid high in the cycle after reset");
      reset_fails++;
    end

  hold_under_backpressure: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_es_valid && !i_es_allowin) |=> (o_es_valid && $stable(o_es_pc)))
    else begin
      $error("o_es_valid or o_es_pc changed while execute held off");
      hold_fails++;
    end

endmodule

bind id_stage tb_id_stage_assertions tb_id_stage_assertions_inst (.*);

//--- vlog.f
id_pkg.sv
id_regfile.sv
id_decoder.sv
id_branch_unit.sv
id_pipe_ctrl.sv
id_stage.sv
tb_id_stage_assertions.sv
tb_id_stage.sv
